// ==== Bender.yml ====
package:
  name: special_registers

sources:
  - hdl/cpuPkg.sv
  - hdl/regOpPkg.sv
  - hdl/registerControl.sv
  - hdl/stackPointer.sv
  - hdl/indexedBank.sv
  - hdl/ioPorts.sv
  - hdl/specialRegisters.sv
  - target: test
    files:
      - verification/specialRegistersTb.sv

// ==== hdl/cpuPkg.sv ====
/*
 * Shared machine constants for the special register unit: word width,
 * register ids and the reset value used by every register block.
 */
`default_nettype none

package cpuPkg;

   localparam int wordWidth  = 16;
   localparam int regIdWidth = 4;
   localparam int bankDepth  = 16;   // entries per base/index bank

   // architectural register ids
   localparam logic [regIdWidth-1:0] regZero    = 4'd0;
   localparam logic [regIdWidth-1:0] regAddress = 4'd1;
   localparam logic [regIdWidth-1:0] regBase    = 4'd2;   // bank
   localparam logic [regIdWidth-1:0] regIndex   = 4'd3;   // bank
   localparam logic [regIdWidth-1:0] regStack   = 4'd4;
   localparam logic [regIdWidth-1:0] regBasePtr = 4'd5;
   localparam logic [regIdWidth-1:0] regInput   = 4'd6;
   localparam logic [regIdWidth-1:0] regOutput  = 4'd7;   // highest legal id

   localparam logic [wordWidth-1:0] wordZero = '0;

endpackage

`default_nettype wire

// ==== hdl/indexedBank.sv ====
/*
 * Small register bank with a synchronous write port and a combinational
 * read port on the same address. Instantiated for the base registers
 * and for the index registers.
 */
`default_nettype none

module indexedBank (
   input  logic                              clock,
   input  logic                              reset,
   input  logic                              write,
   input  logic [regOpPkg::bankIdxWidth-1:0] bankAddr,
   input  logic [cpuPkg::wordWidth-1:0]      bankWriteData,
   output logic [cpuPkg::wordWidth-1:0]      bankReadData
);

   import cpuPkg::*;

   logic [wordWidth-1:0] entries [bankDepth];

   // every entry starts at zero after reset
   always_ff @(posedge clock) begin
      if (reset) begin
         for (int i = 0; i < bankDepth; i++) begin
            entries[i] <= wordZero;
         end
      end else if (write) begin
         entries[bankAddr] <= bankWriteData;
      end
   end

   assign bankReadData = entries[bankAddr];

   // a write to an unknown entry would corrupt the whole bank in simulation
   assert property (@(posedge clock) disable iff (reset)
      write |-> !$isunknown(bankAddr));

endmodule

`default_nettype wire

// ==== hdl/ioPorts.sv ====
/*
 * Input and output registers of the special register unit. The input
 * register samples external data on a strobe; the output register is
 * written by commands and announced with a one-cycle strobe.
 */
`default_nettype none

module ioPorts (
   input  logic                         clock,
   input  logic                         reset,
   input  logic                         inputStrobe,
   input  logic [cpuPkg::wordWidth-1:0] inputData,
   input  logic                         inputWrite,
   input  logic                         outputWrite,
   input  logic [cpuPkg::wordWidth-1:0] ioWriteData,
   output logic [cpuPkg::wordWidth-1:0] inputValue,
   output logic [cpuPkg::wordWidth-1:0] outputData,
   output logic                         outputStrobe
);

   import cpuPkg::*;

   logic [wordWidth-1:0] inputReg;
   logic [wordWidth-1:0] outputReg;

   always_ff @(posedge clock) begin
      if (reset) begin
         inputReg <= wordZero;
      end else if (inputWrite) begin
         inputReg <= ioWriteData;   // command beats the strobe
      end else if (inputStrobe) begin
         inputReg <= inputData;
      end
   end

   always_ff @(posedge clock) begin
      if (reset) begin
         outputReg <= wordZero;
      end else if (outputWrite) begin
         outputReg <= ioWriteData;
      end
   end

   // strobe rises together with the new output value
   always_ff @(posedge clock) begin
      if (reset) begin
         outputStrobe <= 1'b0;
      end else begin
         outputStrobe <= outputWrite;
      end
   end

   assign inputValue = inputReg;
   assign outputData = outputReg;

endmodule

`default_nettype wire

// ==== hdl/regOpPkg.sv ====
/*
 * Command encoding for the special register unit. One 16-bit command
 * word is read either as a register form or as an immediate form,
 * depending on the opcode in the top four bits.
 */
`default_nettype none

package regOpPkg;

   localparam int opWidth       = 4;
   localparam int immWidth      = cpuPkg::wordWidth - opWidth;   // 12
   localparam int bankIdxWidth  = $clog2(cpuPkg::bankDepth);
   localparam int reservedWidth = immWidth - cpuPkg::regIdWidth - bankIdxWidth;

   localparam logic [opWidth-1:0] opWrite      = 4'd1;
   localparam logic [opWidth-1:0] opRead       = 4'd2;
   localparam logic [opWidth-1:0] opPush       = 4'd3;
   localparam logic [opWidth-1:0] opPop        = 4'd4;
   localparam logic [opWidth-1:0] opSetStack   = 4'd5;
   localparam logic [opWidth-1:0] opSetBasePtr = 4'd6;
   // all other opcodes are illegal

   typedef union packed {
      struct packed {
         logic [opWidth-1:0]              opcode;
         logic [cpuPkg::regIdWidth-1:0]   regId;
         logic [bankIdxWidth-1:0]         bankIdx;
         logic [reservedWidth-1:0]        reserved;
      } regForm;   // write, read
      struct packed {
         logic [opWidth-1:0]  opcode;
         logic [immWidth-1:0] imm;
      } immForm;   // setStack, setBasePtr
   } commandWord;

endpackage

`default_nettype wire

// ==== hdl/registerControl.sv ====
/*
 * Command decoder of the special register unit. Turns each accepted
 * command word into write enables for the banks, stack pointer and I/O,
 * keeps the address register and base pointer, and registers read results.
 */
`default_nettype none

module registerControl (
   input  logic                            clock,
   input  logic                            reset,
   input  logic                            cmdValid,
   input  regOpPkg::commandWord            cmdWord,
   input  logic [cpuPkg::wordWidth-1:0]    writeData,
   input  logic [cpuPkg::wordWidth-1:0]    baseReadData,
   input  logic [cpuPkg::wordWidth-1:0]    indexReadData,
   input  logic [cpuPkg::wordWidth-1:0]    stackData,
   input  logic [cpuPkg::wordWidth-1:0]    inputValue,
   input  logic [cpuPkg::wordWidth-1:0]    outputValue,
   output logic                            baseWrite,
   output logic                            indexWrite,
   output logic [regOpPkg::bankIdxWidth-1:0] bankAddr,
   output logic [cpuPkg::wordWidth-1:0]    bankWriteData,
   output logic                            stackInc,
   output logic                            stackDec,
   output logic                            stackLoad,
   output logic [cpuPkg::wordWidth-1:0]    stackLoadData,
   output logic                            inputWrite,
   output logic                            outputWrite,
   output logic [cpuPkg::wordWidth-1:0]    ioWriteData,
   output logic                            readValid,
   output logic [cpuPkg::wordWidth-1:0]    readData,
   output logic                            cmdError
);

   import cpuPkg::*;
   import regOpPkg::*;

   logic [opWidth-1:0]    opcode;
   logic [regIdWidth-1:0] regId;
   logic [wordWidth-1:0]  immValue;
   logic                  opLegal;
   logic                  regLegal;
   logic                  usesReg;
   logic                  isWrite;
   logic                  isRead;
   logic                  isSetStack;
   logic                  isSetBasePtr;
   logic                  isError;
   logic [wordWidth-1:0]  addressReg;
   logic [wordWidth-1:0]  basePtr;
   logic [wordWidth-1:0]  readMux;

   // both views share the opcode field
   assign opcode   = cmdWord.regForm.opcode;
   assign regId    = cmdWord.regForm.regId;
   assign immValue = {{(wordWidth - immWidth){1'b0}}, cmdWord.immForm.imm};   // zero-extend

   assign opLegal  = opcode inside {opWrite, opRead, opPush, opPop, opSetStack, opSetBasePtr};
   assign regLegal = (regId <= regOutput);
   assign usesReg  = (opcode == opWrite) || (opcode == opRead);

   assign isWrite      = cmdValid && (opcode == opWrite) && regLegal;
   assign isRead       = cmdValid && (opcode == opRead) && regLegal;
   assign isSetStack   = cmdValid && (opcode == opSetStack);
   assign isSetBasePtr = cmdValid && (opcode == opSetBasePtr);
   assign isError      = cmdValid && (!opLegal || (usesReg && !regLegal));

   // bank write port, shared address and data
   assign baseWrite     = isWrite && (regId == regBase);
   assign indexWrite    = isWrite && (regId == regIndex);
   assign bankAddr      = cmdWord.regForm.bankIdx;
   assign bankWriteData = writeData;

   // push moves the pointer down, pop moves it up
   assign stackDec      = cmdValid && (opcode == opPush);
   assign stackInc      = cmdValid && (opcode == opPop);
   assign stackLoad     = isSetStack || (isWrite && (regId == regStack));
   assign stackLoadData = isSetStack ? immValue : writeData;

   assign inputWrite  = isWrite && (regId == regInput);
   assign outputWrite = isWrite && (regId == regOutput);
   assign ioWriteData = writeData;

   always_ff @(posedge clock) begin
      if (reset) begin
         addressReg <= wordZero;
         basePtr    <= wordZero;
      end else begin
         if (isWrite && (regId == regAddress))
            addressReg <= writeData;
         if (isSetBasePtr)
            basePtr <= immValue;
         else if (isWrite && (regId == regBasePtr))
            basePtr <= writeData;
      end
   end

   always_comb begin
      case (regId)
         regAddress: readMux = addressReg;
         regBase:    readMux = baseReadData;   // bank entry at bankAddr
         regIndex:   readMux = indexReadData;
         regStack:   readMux = stackData;
         regBasePtr: readMux = basePtr;
         regInput:   readMux = inputValue;
         regOutput:  readMux = outputValue;
         default:    readMux = wordZero;       // zero register
      endcase
   end

   // value sampled before this edge's update
   always_ff @(posedge clock) begin
      if (isRead)
         readData <= readMux;
   end

   always_ff @(posedge clock) begin
      if (reset) begin
         readValid <= 1'b0;
         cmdError  <= 1'b0;
      end else begin
         readValid <= isRead;
         cmdError  <= isError;
      end
   end

   // a response is either data or an error, never both
   assert property (@(posedge clock) disable iff (reset) !(readValid && cmdError));

endmodule

`default_nettype wire

// ==== hdl/specialRegisters.sv ====
/*
 * Top of the special register unit. Connects the command decoder to the
 * base and index banks, the stack pointer and the I/O registers.
 */
`default_nettype none

module specialRegisters (
   input  logic                         clock,
   input  logic                         reset,
   input  logic                         cmdValid,
   input  logic [cpuPkg::wordWidth-1:0] cmdWord,
   input  logic [cpuPkg::wordWidth-1:0] writeData,
   input  logic                         inputStrobe,
   input  logic [cpuPkg::wordWidth-1:0] inputData,
   output logic                         readValid,
   output logic [cpuPkg::wordWidth-1:0] readData,
   output logic                         cmdError,
   output logic                         outputStrobe,
   output logic [cpuPkg::wordWidth-1:0] outputData
);

   import cpuPkg::*;
   import regOpPkg::*;

   logic                    baseWrite;
   logic                    indexWrite;
   logic [bankIdxWidth-1:0] bankAddr;
   logic [wordWidth-1:0]    bankWriteData;
   logic [wordWidth-1:0]    baseReadData;
   logic [wordWidth-1:0]    indexReadData;
   logic                    stackInc;
   logic                    stackDec;
   logic                    stackLoad;
   logic [wordWidth-1:0]    stackLoadData;
   logic [wordWidth-1:0]    stackData;
   logic                    inputWrite;
   logic                    outputWrite;
   logic [wordWidth-1:0]    ioWriteData;
   logic [wordWidth-1:0]    inputValue;

   registerControl control_i (
      .clock, .reset, .cmdValid, .cmdWord, .writeData,
      .baseReadData, .indexReadData, .stackData, .inputValue,
      .outputValue (outputData),   // read back through register 7
      .baseWrite, .indexWrite, .bankAddr, .bankWriteData,
      .stackInc, .stackDec, .stackLoad, .stackLoadData,
      .inputWrite, .outputWrite, .ioWriteData,
      .readValid, .readData, .cmdError
   );

   indexedBank baseBank_i (
      .clock, .reset, .write (baseWrite), .bankAddr, .bankWriteData,
      .bankReadData (baseReadData)
   );

   indexedBank indexBank_i (
      .clock, .reset, .write (indexWrite), .bankAddr, .bankWriteData,
      .bankReadData (indexReadData)
   );

   stackPointer stack_i (
      .clock, .reset, .stackInc, .stackDec, .stackLoad, .stackLoadData, .stackData
   );

   ioPorts io_i (
      .clock, .reset, .inputStrobe, .inputData, .inputWrite, .outputWrite,
      .ioWriteData, .inputValue, .outputData, .outputStrobe
   );

endmodule

`default_nettype wire

// ==== hdl/stackPointer.sv ====
/*
 * Stack pointer of the special register unit. Loaded from a command
 * word or a written value, and moved by one on push and pop with
 * wraparound over the full 16-bit range.
 */
`default_nettype none

module stackPointer (
   input  logic                         clock,
   input  logic                         reset,
   input  logic                         stackInc,
   input  logic                         stackDec,
   input  logic                         stackLoad,
   input  logic [cpuPkg::wordWidth-1:0] stackLoadData,
   output logic [cpuPkg::wordWidth-1:0] stackData
);

   import cpuPkg::*;

   logic [wordWidth-1:0] pointer;

   always_ff @(posedge clock) begin
      if (reset) begin
         pointer <= wordZero;
      end else if (stackLoad) begin
         pointer <= stackLoadData;
      end else if (stackDec) begin
         pointer <= pointer - 1'b1;   // wraps 0 -> ffff
      end else if (stackInc) begin
         pointer <= pointer + 1'b1;   // wraps ffff -> 0
      end
   end

   assign stackData = pointer;

   // decoder issues one command per cycle
   assert property (@(posedge clock) disable iff (reset)
      $onehot0({stackInc, stackDec, stackLoad}));

endmodule

`default_nettype wire

// ==== verification/specialRegistersTb.sv ====
/*
 * Testbench for the special register unit. Drives directed and random
 * commands into specialRegisters and checks read results, error pulses
 * and the output strobe against a register model kept here.
 */
`default_nettype none

module specialRegistersTb;

   import cpuPkg::*;
   import regOpPkg::*;

   localparam int drainLimit = 20;

   logic        clock;
   logic        reset;
   logic        cmdValid;
   logic [15:0] cmdWord;
   logic [15:0] writeData;
   logic        inputStrobe;
   logic [15:0] inputData;
   logic        readValid;
   logic [15:0] readData;
   logic        cmdError;
   logic        outputStrobe;
   logic [15:0] outputData;

   logic [15:0] regs [8];   // model, index = register id
   logic [15:0] baseModel [16];
   logic [15:0] indexModel [16];
   logic        expReadValid;
   logic        expCmdError;
   logic        expOutputStrobe;
   logic [15:0] expReadData;
   int          errorCount;

   specialRegisters dut_i (
      .clock        (clock),
      .reset        (reset),
      .cmdValid     (cmdValid),
      .cmdWord      (cmdWord),
      .writeData    (writeData),
      .inputStrobe  (inputStrobe),
      .inputData    (inputData),
      .readValid    (readValid),
      .readData     (readData),
      .cmdError     (cmdError),
      .outputStrobe (outputStrobe),
      .outputData   (outputData)
   );

   initial clock = 1'b0;
   always #2 clock = ~clock;

   function automatic logic [15:0] modelValue(input logic [3:0] rid, input logic [3:0] idx);
      case (rid)
         4'd0:    return 16'h0000;
         4'd2:    return baseModel[idx];
         4'd3:    return indexModel[idx];
         default: return regs[rid[2:0]];
      endcase
   endfunction

   function automatic logic [15:0] makeReg(input logic [3:0] op, input logic [3:0] rid,
                                           input logic [3:0] idx);
      return {op, rid, idx, 4'h0};
   endfunction

   function automatic logic [15:0] randomCommand();
      logic [3:0]  op;
      logic [15:0] word;
      word = $urandom;
      if ($urandom_range(99) < 6) begin
         op = ($urandom_range(1) == 0) ? 4'd0 : 4'($urandom_range(15, 7));   // illegal
      end else begin
         op = 4'($urandom_range(6, 1));
         if ($urandom_range(9) != 0)
            word[11] = 1'b0;   // mostly legal register ids
      end
      return {op, word[11:0]};
   endfunction

   task automatic checkValue(input string name, input logic [15:0] actual,
                             input logic [15:0] expected);
      if (actual !== expected) begin
         errorCount++;
         $display("[FAIL] %s: expected 0x%h, got 0x%h at time %0t",
                  name, expected, actual, $time);
      end
   endtask

   task automatic checkOutputs();
      checkValue("readValid", {15'b0, readValid}, {15'b0, expReadValid});
      checkValue("cmdError", {15'b0, cmdError}, {15'b0, expCmdError});
      checkValue("outputStrobe", {15'b0, outputStrobe}, {15'b0, expOutputStrobe});
      checkValue("outputData", outputData, regs[7]);
      if (expReadValid)
         checkValue("readData", readData, expReadData);
   endtask

   // update the model for one accepted command
   task automatic predict(input logic [15:0] cmd, input logic [15:0] wd,
                          input logic strb, input logic [15:0] idata);
      logic [3:0] op;
      logic [3:0] rid;
      logic [3:0] idx;
      logic       legalReg;
      op = cmd[15:12];
      rid = cmd[11:8];
      idx = cmd[7:4];
      legalReg = (rid < 4'd8);
      expReadValid = 1'b0;
      expCmdError = 1'b0;
      expOutputStrobe = 1'b0;
      if (op == opRead && legalReg) begin
         expReadValid = 1'b1;
         expReadData = modelValue(rid, idx);   // value before this edge
      end
      if (strb)
         regs[6] = idata;   // overwritten below by a command write
      case (op)
         opWrite: begin
            if (!legalReg)
               expCmdError = 1'b1;
            else if (rid == 4'd2)
               baseModel[idx] = wd;
            else if (rid == 4'd3)
               indexModel[idx] = wd;
            else if (rid != 4'd0)
               regs[rid[2:0]] = wd;
            if (legalReg && rid == 4'd7)
               expOutputStrobe = 1'b1;
         end
         opRead:       expCmdError = !legalReg;
         opPush:       regs[4] = regs[4] - 16'd1;
         opPop:        regs[4] = regs[4] + 16'd1;
         opSetStack:   regs[4] = {4'h0, cmd[11:0]};
         opSetBasePtr: regs[5] = {4'h0, cmd[11:0]};
         default:      expCmdError = 1'b1;
      endcase
   endtask

   task automatic issue(input logic [15:0] cmd, input logic [15:0] wd,
                        input logic strb, input logic [15:0] idata);
      cmdValid = 1'b1;
      cmdWord = cmd;
      writeData = wd;
      inputStrobe = strb;
      inputData = idata;
      predict(cmd, wd, strb, idata);
      @(posedge clock);
      #1;
      cmdValid = 1'b0;
      inputStrobe = 1'b0;
      checkOutputs();
   endtask

   task automatic idle(input logic strb, input logic [15:0] idata);
      cmdValid = 1'b0;
      inputStrobe = strb;
      inputData = idata;
      expReadValid = 1'b0;
      expCmdError = 1'b0;
      expOutputStrobe = 1'b0;
      if (strb)
         regs[6] = idata;
      @(posedge clock);
      #1;
      inputStrobe = 1'b0;
      checkOutputs();
   endtask

   task automatic readAll();
      for (int r = 0; r < 8; r++) begin
         if (r == 2 || r == 3) begin
            for (int i = 0; i < 16; i++)
               issue(makeReg(opRead, 4'(r), 4'(i)), $urandom, 1'b0, 16'h0);
         end else begin
            issue(makeReg(opRead, 4'(r), 4'h0), $urandom, 1'b0, 16'h0);
         end
      end
   endtask

   task automatic waitQuiet(input string what);
      int cycles;
      cycles = 0;
      while ((readValid !== 1'b0 || cmdError !== 1'b0 || outputStrobe !== 1'b0)
             && cycles < drainLimit) begin
         @(posedge clock);
         #1;
         cycles++;
      end
      if (readValid !== 1'b0 || cmdError !== 1'b0 || outputStrobe !== 1'b0) begin
         $display("Timeout: outputs still active after %0d cycles waiting for %s",
                  drainLimit, what);
         $display("Errors: %0d plus one timeout", errorCount);
         $display("Checks failed");
         $finish;
      end
   endtask

   initial begin
      logic [3:0]  idx;
      logic [15:0] word;
      reset = 1'b1;
      cmdValid = 1'b0;
      cmdWord = 16'h0;
      writeData = 16'h0;
      inputStrobe = 1'b0;
      inputData = 16'h0;
      errorCount = 0;
      for (int i = 0; i < 16; i++) begin
         baseModel[i] = 16'h0;
         indexModel[i] = 16'h0;
         if (i < 8)
            regs[i] = 16'h0;
      end
      void'($urandom(76364));
      repeat (3) @(posedge clock);
      #1 reset = 1'b0;
      waitQuiet("reset release");
      idle(1'b0, 16'h0);
      readAll();   // everything zero after reset

      // plain registers, then random bank entries
      issue(makeReg(opWrite, regAddress, 4'h0), 16'hA5C3, 1'b0, 16'h0);
      idle(1'b0, 16'h0);
      issue(makeReg(opRead, regAddress, 4'h0), 16'h0, 1'b0, 16'h0);
      issue(makeReg(opWrite, regBasePtr, 4'h0), $urandom, 1'b0, 16'h0);
      issue(makeReg(opRead, regBasePtr, 4'h0), 16'h0, 1'b0, 16'h0);
      issue(makeReg(opWrite, regOutput, 4'h0), $urandom, 1'b0, 16'h0);
      issue(makeReg(opRead, regOutput, 4'h0), 16'h0, 1'b0, 16'h0);
      issue(makeReg(opWrite, regZero, 4'h0), 16'hFFFF, 1'b0, 16'h0);
      issue(makeReg(opRead, regZero, 4'h0), 16'h0, 1'b0, 16'h0);
      for (int k = 0; k < 8; k++) begin
         idx = $urandom;
         issue(makeReg(opWrite, regBase, idx), $urandom, 1'b0, 16'h0);
         issue(makeReg(opWrite, regIndex, idx), $urandom, 1'b0, 16'h0);
         idle(1'b0, 16'h0);
         issue(makeReg(opRead, regBase, idx), 16'h0, 1'b0, 16'h0);
         issue(makeReg(opRead, regIndex, idx), 16'h0, 1'b0, 16'h0);
      end

      // stack wraparound in both directions
      issue({opSetStack, 12'h000}, 16'h0, 1'b0, 16'h0);
      issue({opPush, 12'h000}, 16'h0, 1'b0, 16'h0);
      issue(makeReg(opRead, regStack, 4'h0), 16'h0, 1'b0, 16'h0);
      issue({opPop, 12'h000}, 16'h0, 1'b0, 16'h0);
      issue(makeReg(opRead, regStack, 4'h0), 16'h0, 1'b0, 16'h0);
      issue(makeReg(opWrite, regStack, 4'h0), 16'hFFFF, 1'b0, 16'h0);
      issue({opPop, 12'h000}, 16'h0, 1'b0, 16'h0);
      issue(makeReg(opRead, regStack, 4'h0), 16'h0, 1'b0, 16'h0);
      issue({opSetStack, 12'hFFF}, 16'h0, 1'b0, 16'h0);
      issue(makeReg(opRead, regStack, 4'h0), 16'h0, 1'b0, 16'h0);
      word = $urandom;
      issue({opSetBasePtr, word[11:0]}, 16'h0, 1'b0, 16'h0);
      issue(makeReg(opRead, regBasePtr, 4'h0), 16'h0, 1'b0, 16'h0);

      // input register, then a command write racing the strobe
      idle(1'b1, $urandom);
      issue(makeReg(opRead, regInput, 4'h0), 16'h0, 1'b0, 16'h0);
      issue(makeReg(opWrite, regInput, 4'h0), $urandom, 1'b1, $urandom);
      issue(makeReg(opRead, regInput, 4'h0), 16'h0, 1'b0, 16'h0);

      // illegal opcodes and register ids
      issue({4'd0, 12'h123}, $urandom, 1'b0, 16'h0);
      for (int op = 7; op < 16; op++)
         issue({4'(op), 12'($urandom)}, $urandom, 1'b0, 16'h0);
      for (int r = 8; r < 16; r++) begin
         issue(makeReg(opWrite, 4'(r), 4'($urandom)), $urandom, 1'b0, 16'h0);
         issue(makeReg(opRead, 4'(r), 4'($urandom)), $urandom, 1'b0, 16'h0);
      end
      readAll();

      // random traffic, mostly back to back
      repeat (400) begin
         if ($urandom_range(4) == 0)
            idle($urandom_range(7) == 0, $urandom);
         else
            issue(randomCommand(), $urandom, $urandom_range(7) == 0, $urandom);
      end
      readAll();
      waitQuiet("final drain");

      $display("Run complete with %0d errors", errorCount);
      if (errorCount == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
hdl/cpuPkg.sv
hdl/regOpPkg.sv
hdl/registerControl.sv
hdl/stackPointer.sv
hdl/indexedBank.sv
hdl/ioPorts.sv
hdl/specialRegisters.sv
verification/specialRegistersTb.sv
